// File: Makefile
TOP = tb_exu

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then \
		echo "simulation did not pass"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
   alu_if.alu alu
);

   // shift amount from the low bits of b only
   logic [4:0] shamt;

   assign shamt = alu.b[4:0];

   always_comb begin
      case (alu.op)
         exu_pkg::ALU_ADD:  alu.res = alu.a + alu.b;
         exu_pkg::ALU_SUB:  alu.res = alu.a - alu.b;
         exu_pkg::ALU_AND:  alu.res = alu.a & alu.b;
         exu_pkg::ALU_OR:   alu.res = alu.a | alu.b;
         exu_pkg::ALU_XOR:  alu.res = alu.a ^ alu.b;
         exu_pkg::ALU_SLT: begin
            alu.res = {{(exu_pkg::XLEN-1){1'b0}}, $signed(alu.a) < $signed(alu.b)};
         end
         exu_pkg::ALU_SLTU: begin
            alu.res = {{(exu_pkg::XLEN-1){1'b0}}, alu.a < alu.b};
         end
         exu_pkg::ALU_SLL:  alu.res = alu.a << shamt;
         exu_pkg::ALU_SRL:  alu.res = alu.a >> shamt;
         // arithmetic shift keeps the sign
         exu_pkg::ALU_SRA:  alu.res = $unsigned($signed(alu.a) >>> shamt);
         default:           alu.res = '0;
      endcase
   end

endmodule

// File: exu_assertions.sv
`timescale 1ns/1ps

module exu_assertions (
   input logic                         clk,
   input logic                         arst_n,
   input logic                         valid,
   input logic                         br_taken,
   input logic [exu_pkg::XLEN-1:0]     brpc,
   input logic                         wb_rf_wen,
   input logic [exu_pkg::REG_BITS-1:0] wb_rf_wnum
);

   int failures = 0;

   // r0 never shows up on the debug port
   no_r0_writeback: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rf_wen |-> wb_rf_wnum != '0)
      else begin
         failures++;
         $error("writeback to r0");
      end

   wb_follows_issue: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rf_wen |-> $past(valid, 2))
      else begin
         failures++;
         $error("writeback without an issue two cycles before");
      end

   branch_follows_issue: assert property (@(posedge clk) disable iff (!arst_n)
      br_taken |-> $past(valid))
      else begin
         failures++;
         $error("taken branch without an issue one cycle before");
      end

   // word aligned target
   brpc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
      br_taken |-> brpc[1:0] == 2'b00)
      else begin
         failures++;
         $error("branch target not word aligned");
      end

endmodule

bind exu_top exu_assertions checks (
   .clk        (clk),
   .arst_n     (arst_n),
   .valid      (valid),
   .br_taken   (br_taken),
   .brpc       (brpc),
   .wb_rf_wen  (wb_rf_wen),
   .wb_rf_wnum (wb_rf_wnum)
);

// File: exu_bru.sv
`timescale 1ns/1ps

module exu_bru (
   bru_if.bru bru
);

   logic cond;

   always_comb begin
      case (bru.op)
         exu_pkg::BRU_BEQ: cond = (bru.a == bru.b);
         exu_pkg::BRU_BNE: cond = (bru.a != bru.b);
         exu_pkg::BRU_BLT: cond = ($signed(bru.a) < $signed(bru.b));
         // bl always goes
         exu_pkg::BRU_BL:  cond = 1'b1;
         default:          cond = 1'b0;
      endcase
   end

   assign bru.taken = bru.valid & cond;

   // offset arrives sign-extended, in words
   assign bru.target  = bru.pc + {bru.offset[exu_pkg::XLEN-3:0], 2'b00};
   assign bru.link_pc = bru.pc + exu_pkg::XLEN'(4);

endmodule

// File: exu_ecl.sv
`timescale 1ns/1ps

module exu_ecl (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         valid,
   input  logic [exu_pkg::XLEN-1:0]     pc,
   input  logic [31:0]                  inst,
   rf_if.ecl                            rf,
   alu_if.ecl                           alu,
   bru_if.ecl                           bru,
   output logic                         br_taken,
   output logic [exu_pkg::XLEN-1:0]     brpc,
   output logic [exu_pkg::XLEN-1:0]     wb_pc,
   output logic                         wb_rf_wen,
   output logic [exu_pkg::REG_BITS-1:0] wb_rf_wnum,
   output logic [exu_pkg::XLEN-1:0]     wb_rf_wdata
);

   exu_pkg::inst_word_u d_inst;

   // decode
   logic                            d_known;
   logic                            d_writes;
   logic                            d_is_br;
   logic                            d_use_imm;
   logic                            d_zero_a;
   logic [exu_pkg::ALU_OP_BITS-1:0] d_alu_op;
   logic [exu_pkg::BRU_OP_BITS-1:0] d_bru_op;
   logic [exu_pkg::XLEN-1:0]        d_offset;
   logic [exu_pkg::XLEN-1:0]        d_imm;
   logic [exu_pkg::REG_BITS-1:0]    d_rs1;
   logic [exu_pkg::REG_BITS-1:0]    d_rs2;
   logic [exu_pkg::REG_BITS-1:0]    d_wnum;
   logic [exu_pkg::XLEN-1:0]        d_src1;
   logic [exu_pkg::XLEN-1:0]        d_src2;

   // execute stage
   logic                            e_valid;
   logic                            e_is_br;
   logic                            e_wr;
   logic [exu_pkg::ALU_OP_BITS-1:0] e_alu_op;
   logic [exu_pkg::BRU_OP_BITS-1:0] e_bru_op;
   logic [exu_pkg::XLEN-1:0]        e_a;
   logic [exu_pkg::XLEN-1:0]        e_b;
   logic [exu_pkg::XLEN-1:0]        e_pc;
   logic [exu_pkg::XLEN-1:0]        e_offset;
   logic [exu_pkg::REG_BITS-1:0]    e_rd;
   logic [exu_pkg::XLEN-1:0]        e_result;

   // writeback stage
   logic                            w_wen;
   logic [exu_pkg::REG_BITS-1:0]    w_rd;
   logic [exu_pkg::XLEN-1:0]        w_data;
   logic [exu_pkg::XLEN-1:0]        w_pc;

   assign d_inst   = inst;
   assign d_rs1    = d_inst.r_form.rj;
   assign d_offset = {{(exu_pkg::XLEN-16){d_inst.i_form.imm16[15]}}, d_inst.i_form.imm16};

   always_comb begin
      d_known   = 1'b1;
      d_writes  = 1'b1;
      d_is_br   = 1'b0;
      d_use_imm = 1'b1;
      d_zero_a  = 1'b0;
      d_alu_op  = exu_pkg::ALU_ADD;
      d_bru_op  = exu_pkg::BRU_BEQ;
      d_imm     = d_offset;
      d_rs2     = d_inst.i_form.rd;
      d_wnum    = d_inst.i_form.rd;
      case (d_inst.r_form.opcode)
         exu_pkg::OPC_RGRP: begin
            d_use_imm = 1'b0;
            d_alu_op  = d_inst.r_form.func[exu_pkg::ALU_OP_BITS-1:0];
            d_rs2     = d_inst.r_form.rk;
         end
         exu_pkg::OPC_ADDI: begin
            d_alu_op = exu_pkg::ALU_ADD;
         end
         exu_pkg::OPC_ANDI: begin
            d_alu_op = exu_pkg::ALU_AND;
            d_imm    = {{(exu_pkg::XLEN-16){1'b0}}, d_inst.i_form.imm16};
         end
         exu_pkg::OPC_ORI: begin
            d_alu_op = exu_pkg::ALU_OR;
            d_imm    = {{(exu_pkg::XLEN-16){1'b0}}, d_inst.i_form.imm16};
         end
         // 0 + imm16 in the upper half
         exu_pkg::OPC_LU12: begin
            d_zero_a = 1'b1;
            d_imm    = {d_inst.i_form.imm16, {(exu_pkg::XLEN-16){1'b0}}};
         end
         exu_pkg::OPC_BEQ: begin
            d_is_br   = 1'b1;
            d_writes  = 1'b0;
            d_use_imm = 1'b0;
            d_bru_op  = exu_pkg::BRU_BEQ;
         end
         exu_pkg::OPC_BNE: begin
            d_is_br   = 1'b1;
            d_writes  = 1'b0;
            d_use_imm = 1'b0;
            d_bru_op  = exu_pkg::BRU_BNE;
         end
         exu_pkg::OPC_BLT: begin
            d_is_br   = 1'b1;
            d_writes  = 1'b0;
            d_use_imm = 1'b0;
            d_bru_op  = exu_pkg::BRU_BLT;
         end
         exu_pkg::OPC_BL: begin
            d_is_br   = 1'b1;
            d_use_imm = 1'b0;
            d_bru_op  = exu_pkg::BRU_BL;
            d_wnum    = exu_pkg::LINK_REG;
         end
         // unknown opcode turns into a bubble
         default: begin
            d_known  = 1'b0;
            d_writes = 1'b0;
         end
      endcase
   end

   assign rf.rs1 = d_rs1;
   assign rf.rs2 = d_rs2;

   // bypass, youngest first; e_wr is never set for r0
   assign d_src1 = (e_valid && e_wr && e_rd == d_rs1) ? e_result :
                   (w_wen && w_rd == d_rs1)          ? w_data   : rf.rs1_data;
   assign d_src2 = (e_valid && e_wr && e_rd == d_rs2) ? e_result :
                   (w_wen && w_rd == d_rs2)          ? w_data   : rf.rs2_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         e_valid <= 1'b0;
         e_is_br <= 1'b0;
         e_wr    <= 1'b0;
      end else begin
         e_valid <= valid && d_known;
         e_is_br <= d_is_br;
         e_wr    <= d_writes && (d_wnum != '0);
      end
   end

   always_ff @(posedge clk) begin
      e_alu_op <= d_alu_op;
      e_bru_op <= d_bru_op;
      e_a      <= d_zero_a ? '0 : d_src1;
      e_b      <= d_use_imm ? d_imm : d_src2;
      e_pc     <= pc;
      e_offset <= d_offset;
      e_rd     <= d_wnum;
   end

   assign alu.a  = e_a;
   assign alu.b  = e_b;
   assign alu.op = e_alu_op;

   // branches compare the same two operands
   assign bru.valid  = e_valid & e_is_br;
   assign bru.op     = e_bru_op;
   assign bru.a      = e_a;
   assign bru.b      = e_b;
   assign bru.pc     = e_pc;
   assign bru.offset = e_offset;

   assign e_result = (e_is_br && e_bru_op == exu_pkg::BRU_BL) ? bru.link_pc : alu.res;

   assign br_taken = bru.taken;
   assign brpc     = bru.target;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         w_wen <= 1'b0;
      end else begin
         w_wen <= e_valid && e_wr;
      end
   end

   always_ff @(posedge clk) begin
      w_rd   <= e_rd;
      w_data <= e_result;
      w_pc   <= e_pc;
   end

   // write port and debug view share the W register
   assign rf.wen      = w_wen;
   assign rf.rd       = w_rd;
   assign rf.wdata    = w_data;
   assign wb_pc       = w_pc;
   assign wb_rf_wen   = w_wen;
   assign wb_rf_wnum  = w_rd;
   assign wb_rf_wdata = w_data;

endmodule

// File: exu_if.sv
`timescale 1ns/1ps

// register file ports, reads combinational
interface rf_if;
   logic [exu_pkg::REG_BITS-1:0] rs1;
   logic [exu_pkg::REG_BITS-1:0] rs2;
   logic [exu_pkg::XLEN-1:0]     rs1_data;
   logic [exu_pkg::XLEN-1:0]     rs2_data;
   logic                         wen;
   logic [exu_pkg::REG_BITS-1:0] rd;
   logic [exu_pkg::XLEN-1:0]     wdata;

   modport ecl (output rs1, rs2, wen, rd, wdata, input rs1_data, rs2_data);
   modport regfile (input rs1, rs2, wen, rd, wdata, output rs1_data, rs2_data);
endinterface

interface alu_if;
   logic [exu_pkg::XLEN-1:0]        a;
   logic [exu_pkg::XLEN-1:0]        b;
   logic [exu_pkg::ALU_OP_BITS-1:0] op;
   logic [exu_pkg::XLEN-1:0]        res;

   modport ecl (output a, b, op, input res);
   modport alu (input a, b, op, output res);
endinterface

// branch compare, target and link address
interface bru_if;
   logic                            valid;
   logic [exu_pkg::BRU_OP_BITS-1:0] op;
   logic [exu_pkg::XLEN-1:0]        a;
   logic [exu_pkg::XLEN-1:0]        b;
   logic [exu_pkg::XLEN-1:0]        pc;
   logic [exu_pkg::XLEN-1:0]        offset;
   logic                            taken;
   logic [exu_pkg::XLEN-1:0]        target;
   logic [exu_pkg::XLEN-1:0]        link_pc;

   modport ecl (
      output valid, op, a, b, pc, offset,
      input  taken, target, link_pc
   );
   modport bru (
      input  valid, op, a, b, pc, offset,
      output taken, target, link_pc
   );
endinterface

// File: exu_pkg.sv
package exu_pkg;

   // datapath and register index widths
   localparam int XLEN     = 32;
   localparam int REG_BITS = 5;

   // bl writes its return address here
   localparam logic [REG_BITS-1:0] LINK_REG = 5'd1;

   // major opcodes, inst[31:26]
   localparam logic [5:0] OPC_RGRP = 6'h00;
   localparam logic [5:0] OPC_ADDI = 6'h01;
   localparam logic [5:0] OPC_ANDI = 6'h02;
   localparam logic [5:0] OPC_ORI  = 6'h03;
   localparam logic [5:0] OPC_LU12 = 6'h04;
   localparam logic [5:0] OPC_BEQ  = 6'h10;
   localparam logic [5:0] OPC_BNE  = 6'h11;
   localparam logic [5:0] OPC_BLT  = 6'h12;
   localparam logic [5:0] OPC_BL   = 6'h13;

   // alu select, the R group carries it in func[3:0]
   localparam int ALU_OP_BITS = 4;
   localparam logic [ALU_OP_BITS-1:0] ALU_ADD  = 4'd0;
   localparam logic [ALU_OP_BITS-1:0] ALU_SUB  = 4'd1;
   localparam logic [ALU_OP_BITS-1:0] ALU_AND  = 4'd2;
   localparam logic [ALU_OP_BITS-1:0] ALU_OR   = 4'd3;
   localparam logic [ALU_OP_BITS-1:0] ALU_XOR  = 4'd4;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLT  = 4'd5;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLTU = 4'd6;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLL  = 4'd7;
   localparam logic [ALU_OP_BITS-1:0] ALU_SRL  = 4'd8;
   localparam logic [ALU_OP_BITS-1:0] ALU_SRA  = 4'd9;

   // branch unit select
   localparam int BRU_OP_BITS = 2;
   localparam logic [BRU_OP_BITS-1:0] BRU_BEQ = 2'd0;
   localparam logic [BRU_OP_BITS-1:0] BRU_BNE = 2'd1;
   localparam logic [BRU_OP_BITS-1:0] BRU_BLT = 2'd2;
   localparam logic [BRU_OP_BITS-1:0] BRU_BL  = 2'd3;

   // one instruction word, register form or immediate form
   typedef union packed {
      struct packed {
         logic [5:0]          opcode;
         logic [10:0]         func;
         logic [REG_BITS-1:0] rk;
         logic [REG_BITS-1:0] rj;
         logic [REG_BITS-1:0] rd;
      } r_form;
      struct packed {
         logic [5:0]          opcode;
         logic [15:0]         imm16;
         logic [REG_BITS-1:0] rj;
         logic [REG_BITS-1:0] rd;
      } i_form;
   } inst_word_u;

endpackage

// File: exu_regfile.sv
`timescale 1ns/1ps

module exu_regfile (
   input  logic  clk,
   input  logic  arst_n,
   rf_if.regfile rf
);

   // r0 has no storage
   logic [exu_pkg::XLEN-1:0] regs [31:1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.wen && rf.rd != '0) begin
         regs[rf.rd] <= rf.wdata;
      end
   end

   assign rf.rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
   assign rf.rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

// File: exu_top.sv
`timescale 1ns/1ps

module exu_top (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         valid,
   input  logic [exu_pkg::XLEN-1:0]     pc,
   input  logic [31:0]                  inst,
   output logic                         br_taken,
   output logic [exu_pkg::XLEN-1:0]     brpc,
   output logic [exu_pkg::XLEN-1:0]     wb_pc,
   output logic                         wb_rf_wen,
   output logic [exu_pkg::REG_BITS-1:0] wb_rf_wnum,
   output logic [exu_pkg::XLEN-1:0]     wb_rf_wdata
);

   rf_if  rf_bus ();
   alu_if alu_bus ();
   bru_if bru_bus ();

   exu_ecl ecl (
      .clk         (clk),
      .arst_n      (arst_n),
      .valid       (valid),
      .pc          (pc),
      .inst        (inst),
      .rf          (rf_bus.ecl),
      .alu         (alu_bus.ecl),
      .bru         (bru_bus.ecl),
      .br_taken    (br_taken),
      .brpc        (brpc),
      .wb_pc       (wb_pc),
      .wb_rf_wen   (wb_rf_wen),
      .wb_rf_wnum  (wb_rf_wnum),
      .wb_rf_wdata (wb_rf_wdata)
   );

   exu_regfile registers (
      .clk    (clk),
      .arst_n (arst_n),
      .rf     (rf_bus.regfile)
   );

   exu_alu alu (
      .alu (alu_bus.alu)
   );

   exu_bru bru (
      .bru (bru_bus.bru)
   );

endmodule

// File: flist.f
exu_pkg.sv
exu_if.sv
exu_regfile.sv
exu_alu.sv
exu_bru.sv
exu_ecl.sv
exu_top.sv
exu_assertions.sv
tb_exu.sv

// File: tb_exu.sv
`timescale 1ns/1ps

module tb_exu;

   localparam time PERIOD    = 8;
   localparam int  MAX_GAP   = 2;
   localparam int  N_PRELOAD = 14;
   localparam int  N_ALU     = 40;
   localparam int  N_IMM     = 12;
   localparam int  N_BYPASS  = 30;
   localparam int  N_BRANCH  = 20;
   localparam int  N_R0      = 5;
   // reset, first idle, every issue with the worst bypass gaps, then drain
   localparam int  WATCHDOG_CYCLES = 5 + 4 + N_PRELOAD + N_ALU + N_IMM
                                     + N_BYPASS * (MAX_GAP + 1) + N_BRANCH + N_R0 + 20;

   localparam logic [5:0] IMM_OPS [4] = '{exu_pkg::OPC_ADDI, exu_pkg::OPC_ANDI,
                                          exu_pkg::OPC_ORI, exu_pkg::OPC_LU12};
   localparam logic [5:0] BR_OPS [4]  = '{exu_pkg::OPC_BEQ, exu_pkg::OPC_BNE,
                                          exu_pkg::OPC_BLT, exu_pkg::OPC_BL};

   typedef struct {
      time                          due;
      string                        name;
      logic [exu_pkg::XLEN-1:0]     pc;
      logic [exu_pkg::REG_BITS-1:0] wnum;
      logic [exu_pkg::XLEN-1:0]     data;
   } wb_exp_t;

   typedef struct {
      time                      due;
      string                    name;
      logic                     taken;
      logic [exu_pkg::XLEN-1:0] target;
   } br_exp_t;

   logic                         clk;
   logic                         arst_n;
   logic                         valid;
   logic [exu_pkg::XLEN-1:0]     pc;
   logic [31:0]                  inst;
   logic                         br_taken;
   logic [exu_pkg::XLEN-1:0]     brpc;
   logic [exu_pkg::XLEN-1:0]     wb_pc;
   logic                         wb_rf_wen;
   logic [exu_pkg::REG_BITS-1:0] wb_rf_wnum;
   logic [exu_pkg::XLEN-1:0]     wb_rf_wdata;

   logic [exu_pkg::XLEN-1:0] ref_regs [32];
   logic [exu_pkg::XLEN-1:0] next_pc;
   int                       errors;
   wb_exp_t                  wb_q [$];
   br_exp_t                  br_q [$];
   wb_exp_t                  wb_e;
   br_exp_t                  br_e;

   exu_top i_dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .valid       (valid),
      .pc          (pc),
      .inst        (inst),
      .br_taken    (br_taken),
      .brpc        (brpc),
      .wb_pc       (wb_pc),
      .wb_rf_wen   (wb_rf_wen),
      .wb_rf_wnum  (wb_rf_wnum),
      .wb_rf_wdata (wb_rf_wdata)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   task automatic stop_run(input string msg);
      errors++;
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_wb(
      input string                        name,
      input logic [exu_pkg::XLEN-1:0]     exp_pc,
      input logic [exu_pkg::REG_BITS-1:0] exp_wnum,
      input logic [exu_pkg::XLEN-1:0]     exp_data,
      input logic [exu_pkg::XLEN-1:0]     act_pc,
      input logic [exu_pkg::REG_BITS-1:0] act_wnum,
      input logic [exu_pkg::XLEN-1:0]     act_data
   );
      if (act_pc !== exp_pc) begin
         stop_run($sformatf("Fail %s: wb_pc expected %h actual %h", name, exp_pc, act_pc));
      end else if (act_wnum !== exp_wnum) begin
         stop_run($sformatf("Fail %s: wb_rf_wnum expected %0d actual %0d",
                            name, exp_wnum, act_wnum));
      end else if (act_data !== exp_data) begin
         stop_run($sformatf("Fail %s: wb_rf_wdata expected %h actual %h",
                            name, exp_data, act_data));
      end
   endtask

   task automatic check_branch(
      input string                    name,
      input logic                     exp_taken,
      input logic [exu_pkg::XLEN-1:0] exp_target,
      input logic                     act_taken,
      input logic [exu_pkg::XLEN-1:0] act_target
   );
      if (act_taken !== exp_taken) begin
         stop_run($sformatf("Fail %s: br_taken expected %b actual %b",
                            name, exp_taken, act_taken));
      end else if (exp_taken && act_target !== exp_target) begin
         stop_run($sformatf("Fail %s: brpc expected %h actual %h", name, exp_target, act_target));
      end
   endtask

   // executes one instruction on ref_regs in program order
   function automatic void model_exec(
      input  logic [31:0]                  word,
      input  logic [exu_pkg::XLEN-1:0]     at_pc,
      output logic                         wen,
      output logic [exu_pkg::REG_BITS-1:0] wnum,
      output logic [exu_pkg::XLEN-1:0]     wdata,
      output logic                         is_br,
      output logic                         taken,
      output logic [exu_pkg::XLEN-1:0]     target
   );
      logic [exu_pkg::XLEN-1:0] a;
      logic [exu_pkg::XLEN-1:0] b;
      logic [exu_pkg::XLEN-1:0] c;
      logic [exu_pkg::XLEN-1:0] sext;
      logic [15:0]              imm;
      imm    = word[25:10];
      a      = ref_regs[word[9:5]];
      b      = ref_regs[word[14:10]];
      c      = ref_regs[word[4:0]];
      sext   = {{16{imm[15]}}, imm};
      wen    = 1'b1;
      wnum   = word[4:0];
      wdata  = '0;
      is_br  = 1'b0;
      taken  = 1'b0;
      target = at_pc + (sext << 2);
      case (word[31:26])
         exu_pkg::OPC_RGRP: begin
            case (word[18:15])
               exu_pkg::ALU_ADD:  wdata = a + b;
               exu_pkg::ALU_SUB:  wdata = a - b;
               exu_pkg::ALU_AND:  wdata = a & b;
               exu_pkg::ALU_OR:   wdata = a | b;
               exu_pkg::ALU_XOR:  wdata = a ^ b;
               exu_pkg::ALU_SLT:  wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               exu_pkg::ALU_SLTU: wdata = (a < b) ? 32'd1 : 32'd0;
               exu_pkg::ALU_SLL:  wdata = a << b[4:0];
               exu_pkg::ALU_SRL:  wdata = a >> b[4:0];
               exu_pkg::ALU_SRA:  wdata = $signed(a) >>> b[4:0];
               default:           wdata = '0;
            endcase
         end
         exu_pkg::OPC_ADDI: wdata = a + sext;
         exu_pkg::OPC_ANDI: wdata = a & {16'h0000, imm};
         exu_pkg::OPC_ORI:  wdata = a | {16'h0000, imm};
         exu_pkg::OPC_LU12: wdata = {imm, 16'h0000};
         exu_pkg::OPC_BEQ: begin
            is_br = 1'b1;
            wen   = 1'b0;
            taken = (a == c);
         end
         exu_pkg::OPC_BNE: begin
            is_br = 1'b1;
            wen   = 1'b0;
            taken = (a != c);
         end
         exu_pkg::OPC_BLT: begin
            is_br = 1'b1;
            wen   = 1'b0;
            taken = ($signed(a) < $signed(c));
         end
         exu_pkg::OPC_BL: begin
            is_br = 1'b1;
            taken = 1'b1;
            wnum  = exu_pkg::LINK_REG;
            wdata = at_pc + 32'd4;
         end
         default: wen = 1'b0;
      endcase
      // r0 keeps zero and shows no writeback
      if (wnum == '0) begin
         wen = 1'b0;
      end
      if (wen) begin
         ref_regs[wnum] = wdata;
      end
   endfunction

   function automatic logic [31:0] r_word(
      input logic [3:0] op,
      input logic [4:0] rk,
      input logic [4:0] rj,
      input logic [4:0] rd
   );
      return {exu_pkg::OPC_RGRP, 7'd0, op, rk, rj, rd};
   endfunction

   function automatic logic [31:0] i_word(
      input logic [5:0]  opc,
      input logic [15:0] imm,
      input logic [4:0]  rj,
      input logic [4:0]  rd
   );
      return {opc, imm, rj, rd};
   endfunction

   function automatic logic [4:0] rand_reg(input int lo);
      return 5'($urandom_range(7, lo));
   endfunction

   // drives one issue on this falling edge and queues what should come back
   task automatic issue(input string name, input logic [31:0] word);
      logic                         wen;
      logic                         is_br;
      logic                         taken;
      logic [exu_pkg::REG_BITS-1:0] wnum;
      logic [exu_pkg::XLEN-1:0]     wdata;
      logic [exu_pkg::XLEN-1:0]     target;
      valid = 1'b1;
      inst  = word;
      pc    = next_pc;
      model_exec(word, next_pc, wen, wnum, wdata, is_br, taken, target);
      if (wen) begin
         wb_q.push_back('{$time + 2 * PERIOD, name, next_pc, wnum, wdata});
      end
      if (is_br) begin
         br_q.push_back('{$time + PERIOD, name, taken, target});
      end
      next_pc = next_pc + 32'd4;
      @(negedge clk);
      valid = 1'b0;
   endtask

   // garbage on inst while valid is low
   task automatic idle(input int cycles);
      repeat (cycles) begin
         inst = $urandom;
         @(negedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (i_dut.checks.failures != 0) begin
         stop_run("a concurrent assertion on the DUT failed");
      end else if (arst_n) begin
         if (wb_q.size() != 0 && wb_q[0].due == $time) begin
            wb_e = wb_q.pop_front();
            if (!wb_rf_wen) begin
               stop_run($sformatf("%s: the instruction at pc %h did not write back",
                                  wb_e.name, wb_e.pc));
            end else begin
               check_wb(wb_e.name, wb_e.pc, wb_e.wnum, wb_e.data,
                        wb_pc, wb_rf_wnum, wb_rf_wdata);
            end
         end else if (wb_rf_wen) begin
            stop_run($sformatf("a writeback to r%0d showed up that no instruction should make",
                               wb_rf_wnum));
         end
         if (br_q.size() != 0 && br_q[0].due == $time) begin
            br_e = br_q.pop_front();
            check_branch(br_e.name, br_e.taken, br_e.target, br_taken, brpc);
         end else if (br_taken) begin
            stop_run("br_taken went high with no branch in execute");
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * PERIOD);
      stop_run("the watchdog expired before the tests finished");
   end

   initial begin
      logic [4:0]  recent [3];
      logic [4:0]  dst;
      void'($urandom(54));
      errors  = 0;
      arst_n  = 1'b0;
      valid   = 1'b0;
      pc      = '0;
      inst    = '0;
      next_pc = 32'h0000_1000;
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      idle(4);

      for (int r = 1; r < 8; r++) begin
         issue("preload", i_word(exu_pkg::OPC_LU12, 16'($urandom), 5'd0, 5'(r)));
         issue("preload", i_word(exu_pkg::OPC_ORI, 16'($urandom), 5'(r), 5'(r)));
      end

      // every alu code at least four times
      for (int i = 0; i < N_ALU; i++) begin
         issue("alu_rr", r_word(4'(i % 10), rand_reg(0), rand_reg(0), rand_reg(1)));
      end

      issue("imm_ext", i_word(exu_pkg::OPC_ADDI, 16'hfff0, 5'd3, 5'd2));
      issue("imm_ext", i_word(exu_pkg::OPC_ANDI, 16'h8f0f, 5'd3, 5'd4));
      issue("imm_ext", i_word(exu_pkg::OPC_ORI, 16'h8000, 5'd0, 5'd5));
      issue("imm_ext", i_word(exu_pkg::OPC_LU12, 16'hbeef, 5'd0, 5'd6));
      for (int i = 4; i < N_IMM; i++) begin
         issue("imm_ext", i_word(IMM_OPS[2'($urandom)], 16'($urandom), rand_reg(0), rand_reg(1)));
      end

      // sources picked from the last three destinations
      recent = '{5'd1, 5'd2, 5'd3};
      for (int i = 0; i < N_BYPASS; i++) begin
         dst = rand_reg(1);
         issue("bypass", r_word(4'($urandom_range(9, 0)), recent[2'($urandom_range(2, 0))],
                                recent[2'($urandom_range(2, 0))], dst));
         recent = '{dst, recent[0], recent[1]};
         idle($urandom_range(MAX_GAP, 0));
      end

      issue("branch", i_word(exu_pkg::OPC_ADDI, 16'd5, 5'd0, 5'd2));
      issue("branch", i_word(exu_pkg::OPC_ADDI, 16'd5, 5'd0, 5'd3));
      issue("branch", i_word(exu_pkg::OPC_ADDI, 16'hfffd, 5'd0, 5'd4));
      issue("branch", i_word(exu_pkg::OPC_BEQ, 16'h0010, 5'd2, 5'd3));
      issue("branch", i_word(exu_pkg::OPC_BNE, 16'h0010, 5'd2, 5'd3));
      issue("branch", i_word(exu_pkg::OPC_BLT, 16'h0020, 5'd4, 5'd2));
      issue("branch", i_word(exu_pkg::OPC_BLT, 16'h0020, 5'd2, 5'd4));
      issue("branch", i_word(exu_pkg::OPC_BEQ, 16'hfff8, 5'd3, 5'd2));
      issue("branch", i_word(exu_pkg::OPC_BL, 16'h0100, 5'd0, 5'd0));
      issue("branch", r_word(exu_pkg::ALU_ADD, 5'd0, 5'd1, 5'd5));
      for (int i = 10; i < N_BRANCH; i++) begin
         issue("branch", i_word(BR_OPS[2'($urandom)], 16'($urandom), rand_reg(0), rand_reg(0)));
      end

      issue("r0_target", i_word(exu_pkg::OPC_ADDI, 16'h0007, 5'd2, 5'd0));
      issue("r0_target", r_word(exu_pkg::ALU_ADD, 5'd3, 5'd2, 5'd0));
      issue("r0_target", i_word(exu_pkg::OPC_LU12, 16'hffff, 5'd0, 5'd0));
      issue("r0_target", r_word(exu_pkg::ALU_OR, 5'd2, 5'd0, 5'd6));
      issue("r0_target", r_word(exu_pkg::ALU_ADD, 5'd0, 5'd0, 5'd7));

      idle(4);
      while (wb_q.size() != 0 || br_q.size() != 0) begin
         @(negedge clk);
      end
      if (errors == 0 && i_dut.checks.failures == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
